//--- common/lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Full LC-3b opcode map, only five are executed
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add  = 2'b00,
		alu_and  = 2'b01,
		alu_not  = 2'b10,
		alu_pass = 2'b11
	} alu_op;

	typedef enum logic [1:0] {
		port_idle = 2'b00,
		port_wait = 2'b01,
		port_hold = 2'b10
	} port_state;

	typedef struct packed {
		lc3b_opcode opcode;
		alu_op aluop;
		logic use_imm;
		logic use_offset;
		logic mem_read;
		logic mem_write;
		logic load_regfile;
		logic wb_sel;       // 1 selects load data
		lc3b_reg dest;
		lc3b_reg sr1;
		lc3b_reg sr2;
	} lc3b_control_word;

	// Bubble, no enables set
	localparam lc3b_control_word nop_ctrl = '{
		opcode: op_br,
		aluop: alu_pass,
		use_imm: 1'b0,
		use_offset: 1'b0,
		mem_read: 1'b0,
		mem_write: 1'b0,
		load_regfile: 1'b0,
		wb_sel: 1'b0,
		dest: 3'b000,
		sr1: 3'b000,
		sr2: 3'b000
	};

	localparam lc3b_word pc_reset = 16'h0000;

endpackage : lc3b_types

//--- logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
	input logic clk,
	input logic rst,
	input logic advance,
	output lc3b_types::lc3b_word pc
);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= lc3b_types::pc_reset;
		end else if (advance) begin
			// Word aligned fetch
			pc <= pc + 16'd2;
		end
	end

endmodule : pc_unit

//--- logic/control_rom.sv
`timescale 1ns/1ps

module control_rom (
	input lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_control_word ctrl
);

	lc3b_types::lc3b_opcode opcode;

	assign opcode = lc3b_types::lc3b_opcode'(ir[15:12]);

	always_comb begin
		ctrl = lc3b_types::nop_ctrl;
		case (opcode)
			lc3b_types::op_add: begin
				ctrl.opcode = opcode;
				ctrl.aluop = lc3b_types::alu_add;
				ctrl.use_imm = ir[5];
				ctrl.load_regfile = 1'b1;
				ctrl.dest = ir[11:9];
				ctrl.sr1 = ir[8:6];
				ctrl.sr2 = ir[2:0];
			end
			lc3b_types::op_and: begin
				ctrl.opcode = opcode;
				ctrl.aluop = lc3b_types::alu_and;
				ctrl.use_imm = ir[5];
				ctrl.load_regfile = 1'b1;
				ctrl.dest = ir[11:9];
				ctrl.sr1 = ir[8:6];
				ctrl.sr2 = ir[2:0];
			end
			lc3b_types::op_not: begin
				ctrl.opcode = opcode;
				ctrl.aluop = lc3b_types::alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.dest = ir[11:9];
				ctrl.sr1 = ir[8:6];
				ctrl.sr2 = ir[2:0];
			end
			lc3b_types::op_ldr: begin
				ctrl.opcode = opcode;
				ctrl.aluop = lc3b_types::alu_add;
				ctrl.use_offset = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.wb_sel = 1'b1;
				ctrl.dest = ir[11:9];
				ctrl.sr1 = ir[8:6];
				ctrl.sr2 = ir[2:0];
			end
			lc3b_types::op_str: begin
				ctrl.opcode = opcode;
				ctrl.aluop = lc3b_types::alu_add;
				ctrl.use_offset = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.sr1 = ir[8:6];
				// Source register sits in the dest field
				ctrl.sr2 = ir[11:9];
			end
			default: begin
				ctrl = lc3b_types::nop_ctrl;
			end
		endcase
	end

endmodule : control_rom

//--- logic/regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic rst,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	input lc3b_types::lc3b_word in,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);

	lc3b_types::lc3b_word data [8];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				data[i] <= '0;
			end
		end else if (load) begin
			data[dest] <= in;
		end
	end

	// Write-through on a same-cycle match
	assign reg_a = (load && dest == src_a) ? in : data[src_a];
	assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule : regfile

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
	input lc3b_types::alu_op aluop,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f
);

	always_comb begin
		case (aluop)
			lc3b_types::alu_add: f = a + b;
			lc3b_types::alu_and: f = a & b;
			lc3b_types::alu_not: f = ~a;
			lc3b_types::alu_pass: f = b;
			default: f = b;
		endcase
	end

endmodule : alu

//--- datapath/mem_port_ctrl.sv
`timescale 1ns/1ps

module mem_port_ctrl (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic request,
	input logic write,
	input logic mem_resp,
	input lc3b_types::lc3b_word mem_rdata_in,
	output lc3b_types::lc3b_word mem_rdata_out,
	output logic ready,
	output logic mem_read,
	output logic mem_write
);

	lc3b_types::port_state state;
	lc3b_types::port_state next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= lc3b_types::port_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			lc3b_types::port_idle: begin
				if (request) begin
					next_state = lc3b_types::port_wait;
				end
			end
			lc3b_types::port_wait: begin
				if (mem_resp) begin
					next_state = lc3b_types::port_hold;
				end
			end
			lc3b_types::port_hold: begin
				// Release only once the pipeline moves on
				if (!stall) begin
					next_state = lc3b_types::port_idle;
				end
			end
			default: begin
				next_state = lc3b_types::port_idle;
			end
		endcase
	end

	// Captured with the response, kept through hold
	always_ff @(posedge clk) begin
		if (state == lc3b_types::port_wait && mem_resp) begin
			mem_rdata_out <= mem_rdata_in;
		end
	end

	assign ready = (state == lc3b_types::port_hold) ||
		(state == lc3b_types::port_idle && !request);

	// Request levels only in wait
	assign mem_read = (state == lc3b_types::port_wait) && !write;
	assign mem_write = (state == lc3b_types::port_wait) && write;

endmodule : mem_port_ctrl

//--- datapath/datapath.sv
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic rst,
	input logic mem_resp_0,
	input logic mem_resp_1,
	input lc3b_types::lc3b_word mem_rdata_0,
	input lc3b_types::lc3b_word mem_rdata_1,
	output lc3b_types::lc3b_word mem_address_0,
	output lc3b_types::lc3b_word mem_address_1,
	output lc3b_types::lc3b_word mem_wdata_1,
	output logic mem_read_0,
	output logic mem_read_1,
	output logic mem_write_1
);

	lc3b_types::lc3b_word pc;
	lc3b_types::lc3b_word ir;
	lc3b_types::lc3b_word fetch_data;
	lc3b_types::lc3b_word load_data;
	logic ready_0;
	logic ready_1;
	logic stall;
	logic load_use;
	logic fetch_stall;

	lc3b_types::lc3b_control_word dec_ctrl;
	lc3b_types::lc3b_word reg_a;
	lc3b_types::lc3b_word reg_b;
	lc3b_types::lc3b_word dec_imm;

	lc3b_types::lc3b_control_word id_ex_ctrl;
	lc3b_types::lc3b_word id_ex_a;
	lc3b_types::lc3b_word id_ex_b;
	lc3b_types::lc3b_word id_ex_imm;
	lc3b_types::lc3b_word fwd_a;
	lc3b_types::lc3b_word fwd_b;
	lc3b_types::lc3b_word alu_b;
	lc3b_types::lc3b_word alu_out;

	lc3b_types::lc3b_control_word ex_mem_ctrl;
	lc3b_types::lc3b_word ex_mem_alu;
	lc3b_types::lc3b_word ex_mem_wdata;

	lc3b_types::lc3b_control_word mem_wb_ctrl;
	lc3b_types::lc3b_word mem_wb_alu;
	lc3b_types::lc3b_word mem_wb_data;
	lc3b_types::lc3b_word wb_value;
	logic wb_load;

	assign stall = ~(ready_0 & ready_1);
	assign fetch_stall = stall | load_use;

	assign mem_address_0 = pc;
	assign mem_address_1 = ex_mem_alu;
	assign mem_wdata_1 = ex_mem_wdata;

	// Fetch
	pc_unit pc_unit_obj (
		.clk,
		.rst,
		.advance(~fetch_stall),
		.pc
	);

	// Port 0 stays in hold through an interlock so the same word is not fetched twice
	mem_port_ctrl mem_ctrl_0 (
		.clk,
		.rst,
		.stall(fetch_stall),
		.request(1'b1),
		.write(1'b0),
		.mem_resp(mem_resp_0),
		.mem_rdata_in(mem_rdata_0),
		.mem_rdata_out(fetch_data),
		.ready(ready_0),
		.mem_read(mem_read_0),
		.mem_write()
	);

	// IR resets to a BR word, which decodes as a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			ir <= 16'h0000;
		end else if (!fetch_stall) begin
			ir <= fetch_data;
		end
	end

	// Decode and register read
	control_rom control_rom_obj (
		.ir,
		.ctrl(dec_ctrl)
	);

	assign wb_load = mem_wb_ctrl.load_regfile & ~stall;

	regfile regfile_obj (
		.clk,
		.rst,
		.load(wb_load),
		.dest(mem_wb_ctrl.dest),
		.src_a(dec_ctrl.sr1),
		.src_b(dec_ctrl.sr2),
		.in(wb_value),
		.reg_a,
		.reg_b
	);

	// Scaled offset6 for LDR/STR, else imm5
	assign dec_imm = dec_ctrl.use_offset ? {{9{ir[5]}}, ir[5:0], 1'b0} : {{11{ir[4]}}, ir[4:0]};

	assign load_use = id_ex_ctrl.mem_read && id_ex_ctrl.load_regfile &&
		(id_ex_ctrl.dest == dec_ctrl.sr1 || id_ex_ctrl.dest == dec_ctrl.sr2);

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex_ctrl <= lc3b_types::nop_ctrl;
		end else if (!stall) begin
			id_ex_ctrl <= load_use ? lc3b_types::nop_ctrl : dec_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_ex_a <= reg_a;
			id_ex_b <= reg_b;
			id_ex_imm <= dec_imm;
		end
	end

	// Execute, newest producer wins
	always_comb begin
		fwd_a = id_ex_a;
		if (ex_mem_ctrl.load_regfile && !ex_mem_ctrl.wb_sel &&
				ex_mem_ctrl.dest == id_ex_ctrl.sr1) begin
			fwd_a = ex_mem_alu;
		end else if (mem_wb_ctrl.load_regfile && mem_wb_ctrl.dest == id_ex_ctrl.sr1) begin
			fwd_a = wb_value;
		end
	end

	always_comb begin
		fwd_b = id_ex_b;
		if (ex_mem_ctrl.load_regfile && !ex_mem_ctrl.wb_sel &&
				ex_mem_ctrl.dest == id_ex_ctrl.sr2) begin
			fwd_b = ex_mem_alu;
		end else if (mem_wb_ctrl.load_regfile && mem_wb_ctrl.dest == id_ex_ctrl.sr2) begin
			fwd_b = wb_value;
		end
	end

	assign alu_b = (id_ex_ctrl.use_imm || id_ex_ctrl.use_offset) ? id_ex_imm : fwd_b;

	alu alu_obj (
		.aluop(id_ex_ctrl.aluop),
		.a(fwd_a),
		.b(alu_b),
		.f(alu_out)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem_ctrl <= lc3b_types::nop_ctrl;
		end else if (!stall) begin
			ex_mem_ctrl <= id_ex_ctrl;
		end
	end

	// STR data comes from sr2
	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_mem_alu <= alu_out;
			ex_mem_wdata <= fwd_b;
		end
	end

	// Memory
	mem_port_ctrl mem_ctrl_1 (
		.clk,
		.rst,
		.stall,
		.request(ex_mem_ctrl.mem_read | ex_mem_ctrl.mem_write),
		.write(ex_mem_ctrl.mem_write),
		.mem_resp(mem_resp_1),
		.mem_rdata_in(mem_rdata_1),
		.mem_rdata_out(load_data),
		.ready(ready_1),
		.mem_read(mem_read_1),
		.mem_write(mem_write_1)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb_ctrl <= lc3b_types::nop_ctrl;
		end else if (!stall) begin
			mem_wb_ctrl <= ex_mem_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			mem_wb_alu <= ex_mem_alu;
			mem_wb_data <= load_data;
		end
	end

	// Writeback
	assign wb_value = mem_wb_ctrl.wb_sel ? mem_wb_data : mem_wb_alu;

endmodule : datapath

//--- test/datapath_chk.sv
`timescale 1ns/1ps

module datapath_chk (
	input logic clk,
	input logic rst,
	input logic mem_resp_0,
	input logic mem_resp_1,
	input lc3b_types::lc3b_word mem_address_0,
	input lc3b_types::lc3b_word mem_address_1,
	input lc3b_types::lc3b_word mem_wdata_1,
	input logic mem_read_0,
	input logic mem_read_1,
	input logic mem_write_1
);

	int fail_count = 0;

	// Requests hold steady until answered
	fetch_held: assert property (@(posedge clk) disable iff (rst)
		mem_read_0 && !mem_resp_0 |=> mem_read_0 && $stable(mem_address_0))
	else begin
		fail_count++;
		$error("port 0 read dropped or moved before its response");
	end

	load_held: assert property (@(posedge clk) disable iff (rst)
		mem_read_1 && !mem_resp_1 |=> mem_read_1 && $stable(mem_address_1))
	else begin
		fail_count++;
		$error("port 1 read dropped or moved before its response");
	end

	store_held: assert property (@(posedge clk) disable iff (rst)
		mem_write_1 && !mem_resp_1 |=>
		mem_write_1 && $stable(mem_address_1) && $stable(mem_wdata_1))
	else begin
		fail_count++;
		$error("port 1 write dropped or changed before its response");
	end

	one_level: assert property (@(posedge clk) disable iff (rst)
		!(mem_read_1 && mem_write_1))
	else begin
		fail_count++;
		$error("port 1 read and write high together");
	end

	// Response only while a request is up, and the request drops right after
	fetch_resp: assert property (@(posedge clk) disable iff (rst)
		mem_resp_0 |-> mem_read_0 ##1 !mem_read_0)
	else begin
		fail_count++;
		$error("port 0 response without a request or request kept after it");
	end

	data_resp: assert property (@(posedge clk) disable iff (rst)
		mem_resp_1 |-> (mem_read_1 || mem_write_1) ##1 !(mem_read_1 || mem_write_1))
	else begin
		fail_count++;
		$error("port 1 response without a request or request kept after it");
	end

endmodule : datapath_chk

//--- test/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb;

	logic clk;
	logic rst;
	logic mem_resp_0;
	logic mem_resp_1;
	lc3b_types::lc3b_word mem_rdata_0;
	lc3b_types::lc3b_word mem_rdata_1;
	lc3b_types::lc3b_word mem_address_0;
	lc3b_types::lc3b_word mem_address_1;
	lc3b_types::lc3b_word mem_wdata_1;
	logic mem_read_0;
	logic mem_read_1;
	logic mem_write_1;

	// Stream 0 builds program and data, streams 1 and 2 time the two ports
	logic [15:0] lfsr_state [3];

	lc3b_types::lc3b_word imem [64];
	lc3b_types::lc3b_word dmem [32768];
	lc3b_types::lc3b_word model_mem [32768];
	lc3b_types::lc3b_word exp_load_addr [$];
	lc3b_types::lc3b_word exp_store_addr [$];
	lc3b_types::lc3b_word exp_store_data [$];

	int value_errors = 0;
	int other_errors = 0;
	int model_stores = 0;
	int stores_seen = 0;
	int fetch_count = 0;
	lc3b_types::lc3b_word next_fetch = lc3b_types::pc_reset;
	logic busy_0 = 1'b0;
	logic busy_1 = 1'b0;
	int left_0 = 0;
	int left_1 = 0;

	datapath dut (.*);

	bind datapath datapath_chk chk (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [15:0] take_bits(input int stream, input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state[stream] = lfsr_next(lfsr_state[stream]);
			v = {v[14:0], lfsr_state[stream][0]};
		end
		return v;
	endfunction

	task automatic check_word(input string name, input lc3b_types::lc3b_word actual,
			input lc3b_types::lc3b_word expected);
		if (actual !== expected) begin
			value_errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			value_errors++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	// Only ADD, AND, NOT, LDR and STR
	task automatic build_program();
		int pick;
		logic [11:0] fields;
		lc3b_types::lc3b_opcode op;
		for (int i = 0; i < 64; i++) begin
			pick = int'(take_bits(0, 3)) % 5;
			fields = 12'(take_bits(0, 12));
			case (pick)
				0: op = lc3b_types::op_add;
				1: op = lc3b_types::op_and;
				2: op = lc3b_types::op_not;
				3: op = lc3b_types::op_ldr;
				default: op = lc3b_types::op_str;
			endcase
			if ((pick == 0 || pick == 1) && !fields[5]) begin
				fields[4:3] = 2'b00;
			end
			if (pick == 2) begin
				fields[5:0] = 6'h3f;
			end
			imem[i] = {op, fields};
		end
	endtask

	task automatic fill_data();
		for (int i = 0; i < 32768; i++) begin
			dmem[i] = take_bits(0, 16);
			model_mem[i] = dmem[i];
		end
	endtask

	// Instruction level reference model
	task automatic run_model();
		lc3b_types::lc3b_word regs [8];
		lc3b_types::lc3b_word ir;
		lc3b_types::lc3b_word imm;
		lc3b_types::lc3b_word offset;
		lc3b_types::lc3b_word addr;
		lc3b_types::lc3b_word src2;
		for (int i = 0; i < 8; i++) begin
			regs[i] = 16'h0000;
		end
		for (int i = 0; i < 64; i++) begin
			ir = imem[i];
			imm = {{11{ir[4]}}, ir[4:0]};
			offset = {{9{ir[5]}}, ir[5:0], 1'b0};
			addr = regs[ir[8:6]] + offset;
			src2 = ir[5] ? imm : regs[ir[2:0]];
			case (lc3b_types::lc3b_opcode'(ir[15:12]))
				lc3b_types::op_add: regs[ir[11:9]] = regs[ir[8:6]] + src2;
				lc3b_types::op_and: regs[ir[11:9]] = regs[ir[8:6]] & src2;
				lc3b_types::op_not: regs[ir[11:9]] = ~regs[ir[8:6]];
				lc3b_types::op_ldr: begin
					exp_load_addr.push_back(addr);
					regs[ir[11:9]] = model_mem[addr[15:1]];
				end
				lc3b_types::op_str: begin
					exp_store_addr.push_back(addr);
					exp_store_data.push_back(regs[ir[11:9]]);
					model_mem[addr[15:1]] = regs[ir[11:9]];
					model_stores++;
				end
				default: begin
				end
			endcase
		end
	endtask

	function automatic lc3b_types::lc3b_word fetch_word(input lc3b_types::lc3b_word addr);
		// Past the program only opcode 0 comes back
		if (addr[15:1] < 64) begin
			return imem[addr[6:1]];
		end
		return 16'h0000;
	endfunction

	task automatic note_load(input lc3b_types::lc3b_word addr);
		if (exp_load_addr.size() == 0) begin
			other_errors++;
			$display("Unexpected load from %h at %0t, none left in the model", addr, $time);
		end else begin
			check_word("mem_address_1", addr, exp_load_addr.pop_front());
		end
	endtask

	task automatic note_store(input lc3b_types::lc3b_word addr,
			input lc3b_types::lc3b_word data);
		stores_seen++;
		if (exp_store_addr.size() == 0) begin
			other_errors++;
			$display("Unexpected store to %h at %0t, none left in the model", addr, $time);
		end else begin
			check_word("mem_address_1", addr, exp_store_addr.pop_front());
			check_word("mem_wdata_1", data, exp_store_data.pop_front());
		end
	endtask

	// Instruction port answers 1 to 4 cycles after each request
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (mem_resp_0) begin
				mem_resp_0 = 1'b0;
			end else if (!rst && mem_read_0) begin
				if (!busy_0) begin
					busy_0 = 1'b1;
					left_0 = int'(take_bits(1, 2)) + 1;
					check_word("mem_address_0", mem_address_0, next_fetch);
					next_fetch = next_fetch + 16'd2;
				end else begin
					left_0--;
				end
				if (busy_0 && left_0 == 0) begin
					busy_0 = 1'b0;
					mem_rdata_0 = fetch_word(mem_address_0);
					mem_resp_0 = 1'b1;
					fetch_count++;
				end
			end
		end
	end

	// Data port
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (mem_resp_1) begin
				mem_resp_1 = 1'b0;
			end else if (!rst && (mem_read_1 || mem_write_1)) begin
				if (!busy_1) begin
					busy_1 = 1'b1;
					left_1 = int'(take_bits(2, 2)) + 1;
					if (mem_read_1) begin
						note_load(mem_address_1);
					end
				end else begin
					left_1--;
				end
				if (busy_1 && left_1 == 0) begin
					busy_1 = 1'b0;
					if (mem_write_1) begin
						note_store(mem_address_1, mem_wdata_1);
						dmem[mem_address_1[15:1]] = mem_wdata_1;
					end else begin
						mem_rdata_1 = dmem[mem_address_1[15:1]];
					end
					mem_resp_1 = 1'b1;
				end
			end
		end
	end

	initial begin : main
		int cycles;
		int assert_errors;
		rst = 1'b1;
		mem_resp_0 = 1'b0;
		mem_resp_1 = 1'b0;
		mem_rdata_0 = 16'h0000;
		mem_rdata_1 = 16'h0000;
		lfsr_state[0] = 16'd74;
		build_program();
		fill_data();
		run_model();
		lfsr_state[1] = take_bits(0, 16) | 16'h0001;
		lfsr_state[2] = take_bits(0, 16) | 16'h0001;

		repeat (4) @(posedge clk);
		#1;
		check_bit("mem_read_0", mem_read_0, 1'b0);
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_bit("mem_read_0", mem_read_0, 1'b1);
		check_bit("mem_read_1", mem_read_1, 1'b0);
		check_bit("mem_write_1", mem_write_1, 1'b0);

		// A few fetches past the end drain the pipeline
		cycles = 0;
		while (fetch_count < 72 && cycles < 4000) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (fetch_count < 72) begin
			other_errors++;
			$display("Timeout: only %0d fetches completed in %0d cycles", fetch_count, cycles);
		end

		if (stores_seen != model_stores) begin
			other_errors++;
			$display("Store count wrong: %0d seen, %0d expected", stores_seen, model_stores);
		end
		if (exp_load_addr.size() != 0) begin
			other_errors++;
			$display("%0d expected loads never appeared", exp_load_addr.size());
		end

		assert_errors = dut.chk.fail_count;
		$display("Errors: %0d value, %0d other, %0d assertion",
			value_errors, other_errors, assert_errors);
		if (value_errors + other_errors + assert_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule : datapath_tb

//--- datapath.f
common/lc3b_types.sv
logic/pc_unit.sv
logic/control_rom.sv
logic/regfile.sv
logic/alu.sv
datapath/mem_port_ctrl.sv
datapath/datapath.sv
test/datapath_chk.sv
test/datapath_tb.sv
